/* tb_input.txt */
# cmd m0_valid m0_addr m0_we m0_be m0_wdata m0_exp m1_valid m1_addr m1_we m1_be m1_wdata m1_exp
# cmd any checks no order, par wants same-cycle grants, m0f or m1f wants that master first
m0f 1 00000010 1 f 11223344 00000000 1 00000020 1 f 01010101 00000000
any 1 00010010 1 f a5a5a5a5 00000000 0 00000000 0 0 00000000 00000000
any 1 00000010 0 f 00000000 11223344 0 00000000 0 0 00000000 00000000
any 1 00010010 0 f 00000000 a5a5a5a5 0 00000000 0 0 00000000 00000000
any 1 00000010 1 5 cafebabe 00000000 0 00000000 0 0 00000000 00000000
any 1 00000010 0 f 00000000 11fe33be 0 00000000 0 0 00000000 00000000
any 0 00000000 0 0 00000000 00000000 1 20000000 0 f 00000000 badacce5
any 0 00000000 0 0 00000000 00000000 1 20000004 1 f 12345678 00000000
any 1 00000400 0 f 00000000 badacce5 0 00000000 0 0 00000000 00000000
par 1 00010020 1 f 02020202 00000000 1 00000020 0 f 00000000 01010101
par 1 00000010 0 f 00000000 11fe33be 1 00010020 0 f 00000000 02020202
m1f 1 00000020 0 f 00000000 01010101 1 00000010 0 f 00000000 11fe33be
m1f 1 00000010 0 f 00000000 11fe33be 1 00000020 0 f 00000000 01010101
m0f 1 00010010 0 f 00000000 a5a5a5a5 1 00010020 0 f 00000000 02020202
m0f 1 00010014 1 f 0badf00d 00000000 1 00010010 0 f 00000000 a5a5a5a5
any 0 00000000 0 0 00000000 00000000 1 00010014 0 f 00000000 0badf00d
m1f 1 40000000 0 f 00000000 badacce5 1 20000000 1 f deadbeef 00000000

/* flist.f */
xbar_pkg.sv
obi_bus_if.sv
addr_decoder.sv
rr_arbiter.sv
system_xbar.sv
sram_slave.sv
error_slave.sv
subsystem_top.sv
tb_subsystem_top.sv

/* Bender.yml */
package:
  name: obi_subsystem_xbar

sources:
  - files:
      - xbar_pkg.sv
      - obi_bus_if.sv
      - addr_decoder.sv
      - rr_arbiter.sv
      - system_xbar.sv
      - sram_slave.sv
      - error_slave.sv
      - subsystem_top.sv
  - target: test
    files:
      - tb_subsystem_top.sv

/* tb_subsystem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_subsystem_top;

    localparam int unsigned GNT_TIMEOUT = 50;

    logic        clk;
    logic        arst_n;

    logic        m0_req;
    logic [31:0] m0_addr;
    logic        m0_we;
    logic [3:0]  m0_be;
    logic [31:0] m0_wdata;
    logic        m0_gnt;
    logic        m0_rvalid;
    logic [31:0] m0_rdata;

    logic        m1_req;
    logic [31:0] m1_addr;
    logic        m1_we;
    logic [3:0]  m1_be;
    logic [31:0] m1_wdata;
    logic        m1_gnt;
    logic        m1_rvalid;
    logic [31:0] m1_rdata;

    int cycle = 0;
    int checks = 0;
    int errors = 0;

    subsystem_top #(
        .RAM_WORDS (256)
    ) i_dut (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .m0_req_i    (m0_req),
        .m0_addr_i   (m0_addr),
        .m0_we_i     (m0_we),
        .m0_be_i     (m0_be),
        .m0_wdata_i  (m0_wdata),
        .m0_gnt_o    (m0_gnt),
        .m0_rvalid_o (m0_rvalid),
        .m0_rdata_o  (m0_rdata),
        .m1_req_i    (m1_req),
        .m1_addr_i   (m1_addr),
        .m1_we_i     (m1_we),
        .m1_be_i     (m1_be),
        .m1_wdata_i  (m1_wdata),
        .m1_gnt_o    (m1_gnt),
        .m1_rvalid_o (m1_rvalid),
        .m1_rdata_o  (m1_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        checks++;
        if (actual !== expected) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic drive_master(
        input int          m,
        input logic        req,
        input logic [31:0] addr,
        input logic        we,
        input logic [3:0]  be,
        input logic [31:0] wdata
    );
        if (m == 0) begin
            m0_req   = req;
            m0_addr  = addr;
            m0_we    = we;
            m0_be    = be;
            m0_wdata = wdata;
        end else begin
            m1_req   = req;
            m1_addr  = addr;
            m1_we    = we;
            m1_be    = be;
            m1_wdata = wdata;
        end
    endtask

    function automatic logic get_gnt(input int m);
        return (m == 0) ? m0_gnt : m1_gnt;
    endfunction

    function automatic logic get_rvalid(input int m);
        return (m == 0) ? m0_rvalid : m1_rvalid;
    endfunction

    function automatic logic [31:0] get_rdata(input int m);
        return (m == 0) ? m0_rdata : m1_rdata;
    endfunction

    // One OBI transfer started on a falling edge
    task automatic do_access(
        input  int          m,
        input  logic [31:0] addr,
        input  logic        we,
        input  logic [3:0]  be,
        input  logic [31:0] wdata,
        input  logic [31:0] exp_rdata,
        output int          gnt_cycle
    );
        int   waited;
        logic granted;
        waited    = 0;
        granted   = 1'b0;
        gnt_cycle = -1;
        drive_master(m, 1'b1, addr, we, be, wdata);
        while (!granted && waited < GNT_TIMEOUT) begin
            #1;
            if (get_gnt(m)) begin
                granted   = 1'b1;
                gnt_cycle = cycle;
                // No response may be pending yet in the grant cycle
                check_value($sformatf("m%0d_rvalid_o", m), get_rvalid(m), 32'd0);
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        if (!granted) begin
            $display("Master %0d got no grant within %0d cycles at address %h",
                     m, GNT_TIMEOUT, addr);
            errors++;
            drive_master(m, 1'b0, '0, 1'b0, '0, '0);
        end else begin
            // Transfer on the next rising edge and the response by the falling edge after it
            @(negedge clk);
            if (!get_rvalid(m)) begin
                $display("Master %0d saw no rvalid one cycle after its grant at address %h",
                         m, addr);
                errors++;
            end else if (!we) begin
                check_value($sformatf("m%0d_rdata_o", m), get_rdata(m), exp_rdata);
            end
            drive_master(m, 1'b0, '0, 1'b0, '0, '0);
        end
    endtask

    initial begin
        int               fd;
        int               code;
        int               gc0;
        int               gc1;
        int               n_lines;
        logic             done;
        logic [8*8-1:0]   cmd;
        logic [8*128-1:0] rest;
        logic [31:0]      f [12];
        n_lines = 0;
        done    = 1'b0;
        gc0     = -1;
        gc1     = -1;
        arst_n  = 1'b0;
        drive_master(0, 1'b0, '0, 1'b0, '0, '0);
        drive_master(1, 1'b0, '0, 1'b0, '0, '0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        fd = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb_input.txt");
            errors++;
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%s", cmd);
                if (code != 1) begin
                    done = 1'b1;
                end else if (cmd == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5],
                                   f[6], f[7], f[8], f[9], f[10], f[11]);
                    if (code != 12) begin
                        $display("Stimulus line %0d is malformed", n_lines + 1);
                        errors++;
                        done = 1'b1;
                    end else begin
                        n_lines++;
                        @(negedge clk);
                        fork
                            if (f[0][0]) do_access(0, f[1], f[2][0], f[3][3:0], f[4], f[5], gc0);
                            if (f[6][0]) do_access(1, f[7], f[8][0], f[9][3:0], f[10], f[11], gc1);
                        join
                        // Grant order when both masters were active
                        if (f[0][0] && f[6][0]) begin
                            if (cmd == "par") begin
                                check_value("m1 grant cycle", gc1, gc0);
                            end else if (cmd == "m0f") begin
                                check_value("m1 grant cycle", gc1, gc0 + 1);
                            end else if (cmd == "m1f") begin
                                check_value("m0 grant cycle", gc0, gc1 + 1);
                            end
                        end
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                $display("The stimulus file held no transactions");
                errors++;
            end
        end

        repeat (2) @(negedge clk);
        $display("Transactions: %0d, checks: %0d, errors: %0d", n_lines, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_subsystem_top

`default_nettype wire

/* subsystem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module subsystem_top #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,

    input  logic                        m0_req_i,
    input  logic [xbar_pkg::ADDR_W-1:0] m0_addr_i,
    input  logic                        m0_we_i,
    input  logic [xbar_pkg::BE_W-1:0]   m0_be_i,
    input  logic [xbar_pkg::DATA_W-1:0] m0_wdata_i,
    output logic                        m0_gnt_o,
    output logic                        m0_rvalid_o,
    output logic [xbar_pkg::DATA_W-1:0] m0_rdata_o,

    input  logic                        m1_req_i,
    input  logic [xbar_pkg::ADDR_W-1:0] m1_addr_i,
    input  logic                        m1_we_i,
    input  logic [xbar_pkg::BE_W-1:0]   m1_be_i,
    input  logic [xbar_pkg::DATA_W-1:0] m1_wdata_i,
    output logic                        m1_gnt_o,
    output logic                        m1_rvalid_o,
    output logic [xbar_pkg::DATA_W-1:0] m1_rdata_o
);
    import xbar_pkg::*;

    obi_bus_if master_if [NMASTER] (.clk_i(clk_i));
    obi_bus_if slave_if  [NSLAVE]  (.clk_i(clk_i));

    // Master 0
    assign master_if[0].req   = m0_req_i;
    assign master_if[0].addr  = m0_addr_i;
    assign master_if[0].we    = m0_we_i;
    assign master_if[0].be    = m0_be_i;
    assign master_if[0].wdata = m0_wdata_i;
    assign m0_gnt_o           = master_if[0].gnt;
    assign m0_rvalid_o        = master_if[0].rvalid;
    assign m0_rdata_o         = master_if[0].rdata;

    // Master 1
    assign master_if[1].req   = m1_req_i;
    assign master_if[1].addr  = m1_addr_i;
    assign master_if[1].we    = m1_we_i;
    assign master_if[1].be    = m1_be_i;
    assign master_if[1].wdata = m1_wdata_i;
    assign m1_gnt_o           = master_if[1].gnt;
    assign m1_rvalid_o        = master_if[1].rvalid;
    assign m1_rdata_o         = master_if[1].rdata;

    system_xbar i_system_xbar (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .master_bus (master_if),
        .slave_bus  (slave_if)
    );

    sram_slave #(
        .RAM_WORDS (RAM_WORDS)
    ) i_ram0 (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .bus      (slave_if[RAM0_IDX])
    );

    sram_slave #(
        .RAM_WORDS (RAM_WORDS)
    ) i_ram1 (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .bus      (slave_if[RAM1_IDX])
    );

    error_slave i_error_slave (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .bus      (slave_if[ERROR_IDX])
    );

endmodule : subsystem_top

`default_nettype wire

/* error_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module error_slave (
    input  logic           clk_i,
    input  logic           arst_n_i,
    obi_bus_if.subordinate bus
);
    import xbar_pkg::*;

    logic rvalid_q;

    // Every access is accepted and writes go nowhere
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.req && bus.gnt;
        end
    end

    assign bus.gnt    = 1'b1;
    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = ERROR_RDATA;

endmodule : error_slave

`default_nettype wire

/* sram_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module sram_slave #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic           clk_i,
    input  logic           arst_n_i,
    obi_bus_if.subordinate bus
);
    import xbar_pkg::*;

    localparam int unsigned IDX_W = $clog2(RAM_WORDS);

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]  word_idx;
    logic              xfer;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;

    // Word address without the byte offset
    assign word_idx = bus.addr[IDX_W+1:2];
    assign xfer     = bus.req && bus.gnt;

    always_ff @(posedge clk_i) begin
        if (xfer && bus.we) begin
            for (int b = 0; b < BE_W; b++) begin
                if (bus.be[b]) begin
                    mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer && !bus.we) begin
            rdata_q <= mem[word_idx];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= xfer;
        end
    end

    assign bus.gnt    = 1'b1;
    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

endmodule : sram_slave

`default_nettype wire

/* system_xbar.sv */
`timescale 1ns/10ps
`default_nettype none

module system_xbar (
    input  logic           clk_i,
    input  logic           arst_n_i,
    obi_bus_if.subordinate master_bus [xbar_pkg::NMASTER],
    obi_bus_if.manager     slave_bus  [xbar_pkg::NSLAVE]
);
    import xbar_pkg::*;

    localparam int unsigned OWN_W = $clog2(NMASTER);

    logic [NMASTER-1:0] m_req;
    logic [ADDR_W-1:0]  m_addr  [NMASTER];
    logic [NMASTER-1:0] m_we;
    logic [BE_W-1:0]    m_be    [NMASTER];
    logic [DATA_W-1:0]  m_wdata [NMASTER];
    logic [SEL_W-1:0]   m_sel   [NMASTER];
    logic [NMASTER-1:0] m_gnt;
    logic [NMASTER-1:0] m_rvalid;
    logic [DATA_W-1:0]  m_rdata [NMASTER];

    logic [NMASTER-1:0] s_req_vec [NSLAVE];
    logic [NMASTER-1:0] s_gnt_vec [NSLAVE];
    logic [OWN_W-1:0]   s_owner   [NSLAVE];
    logic [NSLAVE-1:0]  s_gnt;
    logic [NSLAVE-1:0]  s_rvalid;
    logic [DATA_W-1:0]  s_rdata   [NSLAVE];

    for (genvar m = 0; m < NMASTER; m++) begin : gen_master
        assign m_req[m]   = master_bus[m].req;
        assign m_addr[m]  = master_bus[m].addr;
        assign m_we[m]    = master_bus[m].we;
        assign m_be[m]    = master_bus[m].be;
        assign m_wdata[m] = master_bus[m].wdata;

        assign master_bus[m].gnt    = m_gnt[m];
        assign master_bus[m].rvalid = m_rvalid[m];
        assign master_bus[m].rdata  = m_rdata[m];

        addr_decoder i_addr_decoder (
            .addr_i (m_addr[m]),
            .sel_o  (m_sel[m])
        );
    end

    for (genvar s = 0; s < NSLAVE; s++) begin : gen_slave
        logic [ADDR_W-1:0] fwd_addr;
        logic              fwd_we;
        logic [BE_W-1:0]   fwd_be;
        logic [DATA_W-1:0] fwd_wdata;

        for (genvar m = 0; m < NMASTER; m++) begin : gen_req_vec
            assign s_req_vec[s][m] = m_req[m] && (m_sel[m] == SEL_W'(s));
        end

        assign s_gnt[s]    = slave_bus[s].gnt;
        assign s_rvalid[s] = slave_bus[s].rvalid;
        assign s_rdata[s]  = slave_bus[s].rdata;

        rr_arbiter i_rr_arbiter (
            .clk_i       (clk_i),
            .arst_n_i    (arst_n_i),
            .req_i       (s_req_vec[s]),
            .slave_gnt_i (s_gnt[s]),
            .gnt_o       (s_gnt_vec[s]),
            .owner_o     (s_owner[s])
        );

        // Forward the fields of the granted master
        always_comb begin
            fwd_addr  = '0;
            fwd_we    = 1'b0;
            fwd_be    = '0;
            fwd_wdata = '0;
            for (int m = 0; m < NMASTER; m++) begin
                if (s_gnt_vec[s][m]) begin
                    fwd_addr  = m_addr[m];
                    fwd_we    = m_we[m];
                    fwd_be    = m_be[m];
                    fwd_wdata = m_wdata[m];
                end
            end
        end

        assign slave_bus[s].req   = |s_gnt_vec[s];
        assign slave_bus[s].addr  = fwd_addr;
        assign slave_bus[s].we    = fwd_we;
        assign slave_bus[s].be    = fwd_be;
        assign slave_bus[s].wdata = fwd_wdata;
    end

    // A master is granted by whichever slave port it won
    always_comb begin
        m_gnt = '0;
        for (int s = 0; s < NSLAVE; s++) begin
            m_gnt = m_gnt | s_gnt_vec[s];
        end
    end

    // Response goes to the master recorded by the slave's arbiter
    always_comb begin
        for (int m = 0; m < NMASTER; m++) begin
            m_rvalid[m] = 1'b0;
            m_rdata[m]  = '0;
            for (int s = 0; s < NSLAVE; s++) begin
                if (s_rvalid[s] && (s_owner[s] == OWN_W'(m))) begin
                    m_rvalid[m] = 1'b1;
                    m_rdata[m]  = s_rdata[s];
                end
            end
        end
    end

endmodule : system_xbar

`default_nettype wire

/* rr_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    input  logic [xbar_pkg::NMASTER-1:0]          req_i,
    input  logic                                  slave_gnt_i,
    output logic [xbar_pkg::NMASTER-1:0]          gnt_o,
    output logic [$clog2(xbar_pkg::NMASTER)-1:0]  owner_o
);
    import xbar_pkg::*;

    localparam int unsigned IDX_W = $clog2(NMASTER);

    logic [IDX_W-1:0]   prio_q;
    logic [IDX_W-1:0]   winner;
    logic               found;
    logic [NMASTER-1:0] pick;

    // Search starts at the priority pointer and wraps around
    always_comb begin
        int unsigned idx;
        pick   = '0;
        winner = '0;
        found  = 1'b0;
        for (int unsigned i = 0; i < NMASTER; i++) begin
            idx = (prio_q + i) % NMASTER;
            if (!found && req_i[idx]) begin
                found     = 1'b1;
                winner    = IDX_W'(idx);
                pick[idx] = 1'b1;
            end
        end
    end

    assign gnt_o = slave_gnt_i ? pick : '0;

    // Winner is remembered so the response can be steered back next cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_q  <= '0;
            owner_o <= '0;
        end else if (|gnt_o) begin
            prio_q  <= IDX_W'((winner + 1) % NMASTER);
            owner_o <= winner;
        end
    end

endmodule : rr_arbiter

`default_nettype wire

/* addr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module addr_decoder (
    input  logic [xbar_pkg::ADDR_W-1:0] addr_i,
    output logic [xbar_pkg::SEL_W-1:0]  sel_o
);
    import xbar_pkg::*;

    logic hit_ram0;
    logic hit_ram1;

    assign hit_ram0 = (addr_i >= RAM0_START_ADDRESS) && (addr_i < RAM0_END_ADDRESS);
    assign hit_ram1 = (addr_i >= RAM1_START_ADDRESS) && (addr_i < RAM1_END_ADDRESS);

    // Anything outside the RAM windows lands on the error slave
    always_comb begin
        if (hit_ram0) begin
            sel_o = RAM0_IDX;
        end else if (hit_ram1) begin
            sel_o = RAM1_IDX;
        end else begin
            sel_o = ERROR_IDX;
        end
    end

endmodule : addr_decoder

`default_nettype wire

/* obi_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface obi_bus_if (
    input logic clk_i
);
    import xbar_pkg::*;

    // Request channel
    logic              req;
    logic              gnt;
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;

    // Response channel
    logic              rvalid;
    logic [DATA_W-1:0] rdata;

    modport manager (
        input  clk_i,
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport subordinate (
        input  clk_i,
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface : obi_bus_if

`default_nettype wire

/* xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

    // Bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // Crossbar size
    localparam int unsigned NMASTER = 2;
    localparam int unsigned NSLAVE  = 3;
    localparam int unsigned SEL_W   = 2;

    // Slave port indices
    localparam logic [SEL_W-1:0] RAM0_IDX  = 2'd0;
    localparam logic [SEL_W-1:0] RAM1_IDX  = 2'd1;
    localparam logic [SEL_W-1:0] ERROR_IDX = 2'd2;

    // Address windows with exclusive end addresses
    localparam logic [ADDR_W-1:0] RAM0_START_ADDRESS = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] RAM0_END_ADDRESS   = 32'h0000_0400;
    localparam logic [ADDR_W-1:0] RAM1_START_ADDRESS = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] RAM1_END_ADDRESS   = 32'h0001_0400;

    // Read value of the error slave
    localparam logic [DATA_W-1:0] ERROR_RDATA = 32'hBADA_CCE5;

endpackage : xbar_pkg

`default_nettype wire
